/* logic/fetch_pkg.sv */
`default_nettype none

// ***************************************************************************
// shared widths and constants for the fetch stage
// ***************************************************************************

package fetch_pkg;

	// datapath widths
	localparam int XLEN = 64;
	localparam int ILEN = 32;

	typedef logic [XLEN-1:0] addr_t;
	typedef logic [ILEN-1:0] inst_t;

	// first fetch after reset
	localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

	// cache geometry
	// one line holds two instructions
	localparam int LINE_BYTES  = 8;
	localparam int LINE_BITS   = 64;
	localparam int CACHE_LINES = 16;
	localparam int INDEX_BITS  = 4;
	// 3 offset bits below the index
	localparam int TAG_BITS    = XLEN - INDEX_BITS - 3;

	typedef logic [LINE_BITS-1:0] line_t;

	// rv64i major opcodes seen by the predecoder
	localparam logic [6:0] OPC_JAL    = 7'b110_1111;
	localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

endpackage

`default_nettype wire

/* logic/fetch_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

// ***************************************************************************
// pc register and next pc selection
// ***************************************************************************

module fetch_ctrl
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	// decode side
	input  logic  ready,
	// execute side redirect
	input  logic  redirect,
	input  addr_t redirect_pc,
	// lookup result from the cache
	input  logic  hit,
	// static prediction for the word at pc
	input  logic  pred_taken,
	input  addr_t pred_target,
	output addr_t pc,
	output logic  inst_valid,
	output logic  cancel
);

	addr_t pc_next;
	addr_t pc_seq;
	logic  xfer;

	// a hit is offered to decode unless execute is steering away
	assign inst_valid = hit & ~redirect;

	// tell the cache to ignore a miss on the stale pc
	assign cancel = redirect;

	// instruction handed to decode this cycle
	assign xfer = inst_valid & ready;

	// fall through address
	assign pc_seq = pc + addr_t'(ILEN / 8);

	// next pc priority
	// redirect beats everything, then hold, then prediction
	always_comb begin
		if (redirect) begin
			pc_next = redirect_pc;
		end else if (!xfer) begin
			// miss in progress or decode not ready
			pc_next = pc;
		end else if (pred_taken) begin
			pc_next = pred_target;
		end else begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// ***********************************************************************
	// checks
	// ***********************************************************************

	// no compressed support so every target must stay word aligned,
	// predecoder immediates included
	pc_aligned: assert property (
		@(posedge clk) disable iff (rst)
		pc[1:0] == 2'b00
	);

	// offered word must not slip away while decode stalls
	pc_hold_on_stall: assert property (
		@(posedge clk) disable iff (rst)
		inst_valid && !ready |=> $stable(pc)
	);

endmodule

`default_nettype wire

/* logic/branch_predecode.sv */
`timescale 1ns/10ps
`default_nettype none

// ***************************************************************************
// static branch predecode on the fetched word
// ***************************************************************************

module branch_predecode
	import fetch_pkg::*;
(
	input  inst_t inst,
	input  addr_t pc,
	output logic  pred_taken,
	output addr_t pred_target
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       is_jal;
	logic       is_branch;
	addr_t      imm_j;
	addr_t      imm_b;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	// jal has no funct3
	assign is_jal = (opcode == OPC_JAL);

	// beq bne blt bge bltu bgeu
	// funct3 010 and 011 are reserved under the branch opcode
	always_comb begin
		case (funct3)
			3'b010, 3'b011: is_branch = 1'b0;
			default:        is_branch = (opcode == OPC_BRANCH);
		endcase
	end

	// j-type immediate, 21 bits sign extended
	assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
		inst[30:21], 1'b0};

	// b-type immediate, 13 bits sign extended
	assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
		inst[11:8], 1'b0};

	// jal always taken
	// branch taken only when going backward (sign bit of offset)
	assign pred_taken = is_jal | (is_branch & inst[31]);

	// target relative to the word's own pc
	// only meaningful when pred_taken is high
	assign pred_target = pc + (is_jal ? imm_j : imm_b);

endmodule

`default_nettype wire

/* logic/icache.sv */
`timescale 1ns/10ps
`default_nettype none

// ***************************************************************************
// direct mapped instruction cache with single line refill
// ***************************************************************************

module icache
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	// lookup
	input  addr_t pc,
	input  logic  cancel,
	output logic  hit,
	output inst_t inst,
	// memory port
	output logic  mem_req,
	output addr_t mem_addr,
	input  logic  mem_rvalid,
	input  line_t mem_rdata
);

	typedef enum logic {
		S_IDLE,
		S_WAIT
	} state_t;

	state_t state;

	// storage
	logic [TAG_BITS-1:0] tag_q [CACHE_LINES];
	line_t               data_q [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;

	// lookup fields of pc
	logic [INDEX_BITS-1:0] idx;
	logic [TAG_BITS-1:0]   tag;
	line_t                 rd_line;
	logic                  tag_match;

	// refill fields from the latched request
	logic [INDEX_BITS-1:0] fill_idx;
	logic [TAG_BITS-1:0]   fill_tag;

	logic miss;

	// ***********************************************************************
	// lookup
	// ***********************************************************************

	// 3 offset bits, index, then tag
	assign idx = pc[3 +: INDEX_BITS];
	assign tag = pc[XLEN-1 -: TAG_BITS];

	assign rd_line   = data_q[idx];
	assign tag_match = valid_q[idx] && (tag_q[idx] == tag);

	// no hits reported while a line is in flight
	assign hit = (state == S_IDLE) && tag_match;

	// pc bit 2 picks upper or lower word
	assign inst = pc[2] ? rd_line[LINE_BITS-1 -: ILEN] : rd_line[ILEN-1:0];

	// stale pc during a redirect does not start a refill
	assign miss = (state == S_IDLE) && !tag_match && !cancel;

	// ***********************************************************************
	// refill
	// ***********************************************************************

	assign mem_req = (state == S_WAIT);

	assign fill_idx = mem_addr[3 +: INDEX_BITS];
	assign fill_tag = mem_addr[XLEN-1 -: TAG_BITS];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (miss) begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					// line lands and the lookup retries next cycle
					if (mem_rvalid) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// request address latched on the miss and aligned to the line
	always_ff @(posedge clk) begin
		if (miss) begin
			mem_addr <= pc & ~addr_t'(LINE_BYTES - 1);
		end
	end

	// a line turns valid when its refill lands
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (mem_rvalid) begin
			valid_q[fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_rvalid) begin
			tag_q[fill_idx]  <= fill_tag;
			data_q[fill_idx] <= mem_rdata;
		end
	end

	// ***********************************************************************
	// checks
	// ***********************************************************************

	// request address holds until the line comes back
	mem_addr_stable: assert property (
		@(posedge clk) disable iff (rst)
		mem_req && !mem_rvalid |=> $stable(mem_addr)
	);

	// memory answers only an open request
	rvalid_with_req: assert property (
		@(posedge clk) disable iff (rst)
		mem_rvalid |-> mem_req
	);

	// fetch must never see a hit while the refill is outstanding
	no_hit_in_refill: assert property (
		@(posedge clk) disable iff (rst)
		mem_req |-> !hit
	);

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

// ***************************************************************************
// fetch stage top level
// ***************************************************************************

module fetch_top
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	// decode side
	input  logic  ready,
	input  logic  redirect,
	input  addr_t redirect_pc,
	output logic  inst_valid,
	output inst_t inst,
	output addr_t inst_pc,
	output logic  pred_taken,
	// memory side
	output logic  mem_req,
	output addr_t mem_addr,
	input  logic  mem_rvalid,
	input  line_t mem_rdata
);

	addr_t pc;
	addr_t pred_target;
	logic  hit;
	logic  cancel;

	// pc of the offered word
	assign inst_pc = pc;

	fetch_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.ready       (ready),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.hit         (hit),
		.pred_taken  (pred_taken),
		.pred_target (pred_target),
		.pc          (pc),
		.inst_valid  (inst_valid),
		.cancel      (cancel)
	);

	branch_predecode u_predecode (
		.inst        (inst),
		.pc          (pc),
		.pred_taken  (pred_taken),
		.pred_target (pred_target)
	);

	icache u_icache (
		.clk        (clk),
		.rst        (rst),
		.pc         (pc),
		.cancel     (cancel),
		.hit        (hit),
		.inst       (inst),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata)
	);

endmodule

`default_nettype wire

/* sim/fetch_checks.svh */
`ifndef FETCH_CHECKS_SVH
`define FETCH_CHECKS_SVH

// ***************************************************************************
// compare tasks
// ***************************************************************************

task automatic stop_run(string msg);
	$display("%s", msg);
	$display("SIMULATION FAILED");
	$fatal(1);
endtask

task automatic check_addr(string name, addr_t got, addr_t exp);
	if (got !== exp) begin
		stop_run($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	end
endtask

task automatic check_inst(string name, inst_t got, inst_t exp);
	if (got !== exp) begin
		stop_run($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	end
endtask

task automatic check_bit(string name, logic got, logic exp);
	if (got !== exp) begin
		stop_run($sformatf("Error at %0t: %s = %b, expected %b", $time, name, got, exp));
	end
endtask

// ***************************************************************************
// stimulus helpers and directed tests
// ***************************************************************************

// take n words and check each against the program and the next pc rule
task automatic accept_n(int n, logic no_refill);
	logic req_q;
	repeat (n) begin
		req_q = mem_req;
		do begin
			@(negedge clk);
			ready = 1'b1;
			redirect = 1'b0;
			#1;
			if (no_refill) begin
				check_bit("mem_req", mem_req, 1'b0);
			end
			// a request that opens here fetches the line of the expected word
			if (mem_req && !req_q) begin
				check_addr("mem_addr", mem_addr, {exp_pc[63:3], 3'b000});
			end
			req_q = mem_req;
		end while (!inst_valid);
		check_addr("inst_pc", inst_pc, exp_pc);
		check_inst("inst", inst, word_at(exp_pc));
		check_bit("pred_taken", pred_taken, target_of.exists(exp_pc) != 0);
		exp_pc = target_of.exists(exp_pc) ? target_of[exp_pc] : exp_pc + 64'd4;
	end
endtask

// redirect pulse on the current falling edge
task automatic steer_to(addr_t target);
	redirect = 1'b1;
	redirect_pc = target;
	#1;
	check_bit("inst_valid", inst_valid, 1'b0);
	exp_pc = target;
endtask

// decode stalls until a word is on offer
task automatic stall_until_offered();
	do begin
		@(negedge clk);
		ready = 1'b0;
		redirect = 1'b0;
		#1;
	end while (!inst_valid);
endtask

// idle outputs after reset and a straight run over six cold lines
task automatic test_reset_and_sequence();
	#1;
	check_bit("inst_valid", inst_valid, 1'b0);
	check_bit("mem_req", mem_req, 1'b0);
	exp_pc = RESET_PC;
	accept_n(12, 1'b0);
endtask

// same lines again and every one of them hits
task automatic test_rehit();
	@(negedge clk);
	steer_to(RESET_PC);
	accept_n(8, 1'b1);
endtask

// jal forward then jal backward
task automatic test_jal();
	put_jal(64'h8000_1000, 64);
	put_jal(64'h8000_1040, -32);
	@(negedge clk);
	steer_to(64'h8000_1000);
	accept_n(3, 1'b0);
endtask

// forward bne, reserved funct3, then a backward beq to the top
task automatic test_branch();
	put_branch(64'h8000_2004, 3'd1, 12);
	put_branch(64'h8000_2008, 3'd2, -8);
	put_branch(64'h8000_200c, 3'd0, -12);
	@(negedge clk);
	steer_to(64'h8000_2004);
	accept_n(5, 1'b0);
endtask

task automatic test_redirect();
	// park the jal on the outputs
	@(negedge clk);
	steer_to(64'h8000_1000);
	stall_until_offered();
	check_bit("pred_taken", pred_taken, 1'b1);
	@(negedge clk);
	steer_to(64'h8000_3000);
	accept_n(1, 1'b0);
	// redirect on the first cycle of a cold line refill
	@(negedge clk);
	steer_to(64'h8000_4010);
	do begin
		@(negedge clk);
		redirect = 1'b0;
	end while (!mem_req);
	steer_to(64'h8000_1000);
	accept_n(1, 1'b0);
endtask

task automatic test_backpressure();
	int unsigned hold_cycles;
	addr_t held_pc;
	inst_t held_inst;
	logic  held_taken;
	hold_cycles = $urandom_range(9, 2);
	put_jal(64'h8000_5004, 32);
	@(negedge clk);
	steer_to(64'h8000_5000);
	accept_n(1, 1'b0);
	stall_until_offered();
	held_pc = exp_pc;
	held_inst = word_at(exp_pc);
	held_taken = target_of.exists(exp_pc) != 0;
	repeat (hold_cycles) begin
		@(negedge clk);
		#1;
		check_addr("held inst_pc", inst_pc, held_pc);
		check_inst("held inst", inst, held_inst);
		check_bit("held pred_taken", pred_taken, held_taken);
	end
	// stalled jal first and then its target
	accept_n(3, 1'b0);
endtask

`endif

/* sim/tb_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch
	import fetch_pkg::*;
();

	localparam int CLK_HALF_NS  = 2;
	localparam int RESET_CYCLES = 10;
	// transfers in the whole sequence rounded up
	localparam int PLANNED_XFERS = 40;
	// miss cycle, up to six memory cycles, fill, retry
	localparam int MISS_CYCLES = 9;
	// stall and redirect cycles ride in the margin
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + PLANNED_XFERS * MISS_CYCLES + 100) * 2 * CLK_HALF_NS;

	logic  clk;
	logic  rst;
	// decode and execute side
	logic  ready;
	logic  redirect;
	addr_t redirect_pc;
	logic  inst_valid;
	inst_t inst;
	addr_t inst_pc;
	logic  pred_taken;
	// memory side
	logic  mem_req;
	addr_t mem_addr;
	logic  mem_rvalid;
	line_t mem_rdata;

	// sparse program and the target of each taken word
	inst_t prog [addr_t];
	addr_t target_of [addr_t];
	// inst_pc the next transfer must show
	addr_t exp_pc;

	always #(CLK_HALF_NS) clk = ~clk;

	fetch_top UUT (.*);

	// untouched addresses read as addi words hashed from the full address
	function automatic inst_t word_at(addr_t a);
		logic [31:0] h;
		h = a[63:32] ^ a[31:0];
		if (prog.exists(a)) begin
			return prog[a];
		end
		return {h[31:7] ^ h[24:0], 7'b001_0011};
	endfunction

	// jal x1 is always predicted taken
	task automatic put_jal(addr_t a, int off);
		logic [20:0] imm;
		imm = off[20:0];
		prog[a] = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
		target_of[a] = a + addr_t'(off);
	endtask

	// taken only for a real funct3 with a negative offset
	task automatic put_branch(addr_t a, logic [2:0] f3, int off);
		logic [12:0] imm;
		imm = off[12:0];
		prog[a] = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
		if (off < 0 && f3 != 3'd2 && f3 != 3'd3) begin
			target_of[a] = a + addr_t'(off);
		end
	endtask

	// memory model
	// each request gets one line after 1 to 6 falling edges
	task automatic serve_memory();
		int unsigned wait_cycles;
		forever begin
			@(negedge clk);
			mem_rvalid = 1'b0;
			if (mem_req) begin
				wait_cycles = $urandom_range(6, 1);
				repeat (wait_cycles - 1) @(negedge clk);
				// lower word at the line address
				mem_rdata = {word_at(mem_addr + 64'd4), word_at(mem_addr)};
				mem_rvalid = 1'b1;
			end
		end
	endtask

	`include "fetch_checks.svh"

	initial begin
		void'($urandom(32'h2946_5778));
		clk = 1'b0;
		rst = 1'b1;
		ready = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		// memory model runs for the whole simulation
		fork
			serve_memory();
		join_none
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		test_reset_and_sequence();
		test_rehit();
		test_jal();
		test_branch();
		test_redirect();
		test_backpressure();
		$display("SIMULATION PASSED");
		$finish;
	end

	// ends a run where fetch stops making progress
	initial begin
		#(WATCHDOG_NS);
		stop_run("timeout: the watchdog expired before all tests finished");
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+sim
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/branch_predecode.sv
logic/icache.sv
logic/fetch_top.sv
sim/tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_stage

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_ctrl.sv
  - logic/branch_predecode.sv
  - logic/icache.sv
  - logic/fetch_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fetch.sv
